//--- alu_pkg.sv
// Opcodes, command and result field layout and sizes shared by the ALU coprocessor RTL and testbench
package alu_pkg;

	// Datapath and bus widths
	localparam int ALU_BYTE_W = 8;
	localparam int ALU_WORD_W = 32;
	localparam int ALU_ADR_W  = 2;
	localparam int ALU_OP_W   = 4;

	// Codes 14 and 15 are left unassigned and pass A through
	typedef enum logic [ALU_OP_W-1:0] {
		OP_ADD  = 4'd0,
		OP_ADDC = 4'd1,
		OP_SUBB = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		OP_CPL  = 4'd6,
		OP_RR   = 4'd7,
		OP_RL   = 4'd8,
		OP_RRC  = 4'd9,
		OP_RLC  = 4'd10,
		OP_SWAP = 4'd11,
		OP_DA   = 4'd12,
		OP_MUL  = 4'd13
	} alu_op_t;

	// Command word, low to high
	localparam int ALU_CMD_W      = 22;
	localparam int ALU_CMD_A_LSB  = 0;
	localparam int ALU_CMD_B_LSB  = 8;
	localparam int ALU_CMD_OP_LSB = 16;
	localparam int ALU_CMD_CY_BIT = 20;
	localparam int ALU_CMD_AC_BIT = 21;

	// Result word, low to high
	localparam int ALU_RES_W      = 20;
	localparam int ALU_RES_LO_LSB = 0;
	localparam int ALU_RES_HI_LSB = 8;
	localparam int ALU_RES_P_BIT  = 16;
	localparam int ALU_RES_OV_BIT = 17;
	localparam int ALU_RES_AC_BIT = 18;
	localparam int ALU_RES_CY_BIT = 19;

	// Word addresses on the slave port
	localparam logic [ALU_ADR_W-1:0] ALU_ADR_CMD = 2'd0;
	localparam logic [ALU_ADR_W-1:0] ALU_ADR_RES = 2'd1;

	localparam int ALU_QUEUE_DEPTH = 4;
	localparam int ALU_MUL_STEPS   = 8;

endpackage

//--- alu_queue.sv
// Circular FIFO with a type-parameterized payload, instantiated for both commands and results
module alu_queue
	import alu_pkg::*;
#(
	parameter type payload_t = logic [ALU_CMD_W-1:0]
)
(
	input  logic     clk,
	input  logic     reset_n,
	input  logic     i_push,
	input  logic     i_pop,
	input  payload_t i_data,
	output payload_t o_data,
	output logic     o_full,
	output logic     o_empty
);
	localparam int PTR_W = $clog2(ALU_QUEUE_DEPTH);
	localparam int CNT_W = $clog2(ALU_QUEUE_DEPTH + 1);

	payload_t         mem [ALU_QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Wrap at the last entry, also for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(ALU_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (i_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (i_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({i_push, i_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (i_push)
			mem[wr_ptr] <= i_data;
	end

	// Head stays visible while not empty
	assign o_data  = mem[rd_ptr];
	assign o_full  = (count == CNT_W'(ALU_QUEUE_DEPTH));
	assign o_empty = (count == '0);

endmodule

//--- alu_bus_port.sv
// Wishbone classic slave that turns command writes into queue pushes and result reads into pops
module alu_bus_port
	import alu_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	input  logic                  i_wb_we,
	input  logic [ALU_ADR_W-1:0]  i_wb_adr,
	input  logic [ALU_WORD_W-1:0] i_wb_dat,
	output logic [ALU_WORD_W-1:0] o_wb_dat,
	output logic                  o_wb_ack,
	output logic                  o_cmd_push,
	output logic [ALU_CMD_W-1:0]  o_cmd_data,
	input  logic                  i_cmd_full,
	output logic                  o_res_pop,
	input  logic [ALU_RES_W-1:0]  i_res_data,
	input  logic                  i_res_empty
);
	logic req;
	logic is_cmd;
	logic is_res;
	logic stall;
	logic accept;

	// A request is not seen again in its own ack cycle
	assign req    = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign is_cmd = (i_wb_adr == ALU_ADR_CMD);
	assign is_res = (i_wb_adr == ALU_ADR_RES);

	// Back-pressure on a full command queue or an empty result queue
	assign stall  = (i_wb_we && is_cmd && i_cmd_full) || (!i_wb_we && is_res && i_res_empty);
	assign accept = req && !stall;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			o_wb_ack   <= 1'b0;
			o_cmd_push <= 1'b0;
			o_res_pop  <= 1'b0;
		end
		else
		begin
			o_wb_ack   <= accept;
			o_cmd_push <= accept && i_wb_we && is_cmd;
			o_res_pop  <= accept && !i_wb_we && is_res;
		end
	end

	// Command and read data go out together with ack
	always_ff @(posedge clk)
	begin
		if (accept && i_wb_we && is_cmd)
			o_cmd_data <= i_wb_dat[ALU_CMD_W-1:0];
		if (accept && !i_wb_we)
			o_wb_dat <= is_res ? ALU_WORD_W'(i_res_data) : '0;
	end

endmodule

//--- alu_shift_add_mul.sv
// Iterative shift-and-add byte multiplier started by a one-cycle pulse from the execution unit
module alu_shift_add_mul
	import alu_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    i_start,
	input  logic [ALU_BYTE_W-1:0]   i_a,
	input  logic [ALU_BYTE_W-1:0]   i_b,
	output logic                    o_done,
	output logic [2*ALU_BYTE_W-1:0] o_product
);
	localparam int STEP_W = $clog2(ALU_MUL_STEPS);

	typedef enum logic [1:0] {M_IDLE, M_SHIFT, M_DONE} mul_state_t;

	mul_state_t              state;
	logic [STEP_W-1:0]       step;
	logic [2*ALU_BYTE_W-1:0] mcand;
	logic [2*ALU_BYTE_W-1:0] acc;
	logic [ALU_BYTE_W-1:0]   mplier;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= M_IDLE;
			step  <= '0;
		end
		else
		begin
			case (state)
				M_IDLE:
					if (i_start)
					begin
						state <= M_SHIFT;
						step  <= '0;
					end
				M_SHIFT:
				begin
					step <= step + 1'b1;
					if (step == STEP_W'(ALU_MUL_STEPS - 1))
						state <= M_DONE;
				end
				default:
					state <= M_IDLE;
			endcase
		end
	end

	// One multiplier bit per step, LSB first
	always_ff @(posedge clk)
	begin
		if (state == M_IDLE && i_start)
		begin
			mcand  <= (2*ALU_BYTE_W)'(i_a);
			mplier <= i_b;
			acc    <= '0;
		end
		else if (state == M_SHIFT)
		begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign o_done    = (state == M_DONE);
	assign o_product = acc;

endmodule

//--- alu_exec.sv
// Execution unit that pops one command, computes the byte result and flags, and pushes a result
module alu_exec
	import alu_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic [ALU_CMD_W-1:0] i_cmd_data,
	input  logic                 i_cmd_empty,
	output logic                 o_cmd_pop,
	output logic                 o_res_push,
	output logic [ALU_RES_W-1:0] o_res_data,
	input  logic                 i_res_full
);
	typedef enum logic [1:0] {S_IDLE, S_EXEC, S_MUL, S_PUSH} state_t;

	state_t                  state;
	logic [ALU_CMD_W-1:0]    cmd_q;
	logic [ALU_RES_W-1:0]    res_q;
	logic [ALU_RES_W-1:0]    res_d;
	alu_op_t                 op;
	logic [ALU_BYTE_W-1:0]   a;
	logic [ALU_BYTE_W-1:0]   b;
	logic [ALU_BYTE_W-1:0]   b_eff;
	logic                    cy_in;
	logic                    ac_in;
	logic                    c_in;
	logic                    c3;
	logic                    c6;
	logic                    c7;
	logic [3:0]              sum_lo;
	logic [2:0]              sum_mid;
	logic                    sum_top;
	logic [ALU_BYTE_W:0]     da_sum;
	logic [ALU_BYTE_W-1:0]   lo;
	logic [ALU_BYTE_W-1:0]   hi;
	logic                    cy;
	logic                    ac;
	logic                    ov;
	logic                    mul_start;
	logic                    mul_done;
	logic [2*ALU_BYTE_W-1:0] mul_product;

	assign a     = cmd_q[ALU_CMD_A_LSB +: ALU_BYTE_W];
	assign b     = cmd_q[ALU_CMD_B_LSB +: ALU_BYTE_W];
	assign op    = alu_op_t'(cmd_q[ALU_CMD_OP_LSB +: ALU_OP_W]);
	assign cy_in = cmd_q[ALU_CMD_CY_BIT];
	assign ac_in = cmd_q[ALU_CMD_AC_BIT];

	// SUBB runs as A + ~B + ~cy, so carries come out as inverted borrows
	assign b_eff = (op == OP_SUBB) ? ~b : b;
	assign c_in  = (op == OP_ADDC) ? cy_in : ((op == OP_SUBB) ? ~cy_in : 1'b0);
	assign {c3, sum_lo}  = 5'(a[3:0]) + 5'(b_eff[3:0]) + 5'(c_in);
	assign {c6, sum_mid} = 4'(a[6:4]) + 4'(b_eff[6:4]) + 4'(c3);
	assign {c7, sum_top} = 2'(a[7]) + 2'(b_eff[7]) + 2'(c6);

	// Both DA corrections judged on the original nibbles
	assign da_sum = (ALU_BYTE_W+1)'(a)
		+ (((a[3:0] > 4'd9) || ac_in) ? 9'h006 : 9'h000)
		+ (((a[7:4] > 4'd9) || cy_in) ? 9'h060 : 9'h000);

	always_comb
	begin
		lo = a;
		hi = '0;
		cy = cy_in;
		ac = ac_in;
		ov = 1'b0;
		case (op)
			OP_ADD, OP_ADDC, OP_SUBB:
			begin
				lo = {sum_top, sum_mid, sum_lo};
				cy = (op == OP_SUBB) ? ~c7 : c7;
				ac = (op == OP_SUBB) ? ~c3 : c3;
				ov = c6 ^ c7;
			end
			OP_AND:  lo = a & b;
			OP_OR:   lo = a | b;
			OP_XOR:  lo = a ^ b;
			OP_CPL:  lo = ~a;
			OP_RR:   lo = {a[0], a[7:1]};
			OP_RL:   lo = {a[6:0], a[7]};
			OP_RRC:
			begin
				lo = {cy_in, a[7:1]};
				cy = a[0];
			end
			OP_RLC:
			begin
				lo = {a[6:0], cy_in};
				cy = a[7];
			end
			OP_SWAP: lo = {a[3:0], a[7:4]};
			OP_DA:
			begin
				lo = da_sum[ALU_BYTE_W-1:0];
				cy = da_sum[ALU_BYTE_W] | cy_in;
			end
			OP_MUL:
			begin
				{hi, lo} = mul_product;
				cy = 1'b0;
				ov = |mul_product[2*ALU_BYTE_W-1:ALU_BYTE_W];
			end
			default: lo = a;
		endcase
	end

	assign res_d[ALU_RES_LO_LSB +: ALU_BYTE_W] = lo;
	assign res_d[ALU_RES_HI_LSB +: ALU_BYTE_W] = hi;
	assign res_d[ALU_RES_P_BIT]  = ^lo;
	assign res_d[ALU_RES_OV_BIT] = ov;
	assign res_d[ALU_RES_AC_BIT] = ac;
	assign res_d[ALU_RES_CY_BIT] = cy;

	assign mul_start = (state == S_EXEC) && (op == OP_MUL);

	alu_shift_add_mul mul (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_start   (mul_start),
		.i_a       (a),
		.i_b       (b),
		.o_done    (mul_done),
		.o_product (mul_product)
	);

	// Latch, compute, then hold until the result queue has room
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			state <= S_IDLE;
		else
		begin
			case (state)
				S_IDLE:
					if (!i_cmd_empty)
						state <= S_EXEC;
				S_EXEC:
					state <= (op == OP_MUL) ? S_MUL : S_PUSH;
				S_MUL:
					if (mul_done)
						state <= S_PUSH;
				default:
					if (!i_res_full)
						state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (o_cmd_pop)
			cmd_q <= i_cmd_data;
		if ((state == S_EXEC && op != OP_MUL) || (state == S_MUL && mul_done))
			res_q <= res_d;
	end

	assign o_cmd_pop  = (state == S_IDLE) && !i_cmd_empty;
	assign o_res_push = (state == S_PUSH) && !i_res_full;
	assign o_res_data = res_q;

endmodule

//--- alu_core_top.sv
// Top level wiring the bus port, the command and result queues and the execution unit
module alu_core_top
	import alu_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  i_wb_cyc,
	input  logic                  i_wb_stb,
	input  logic                  i_wb_we,
	input  logic [ALU_ADR_W-1:0]  i_wb_adr,
	input  logic [ALU_WORD_W-1:0] i_wb_dat,
	output logic [ALU_WORD_W-1:0] o_wb_dat,
	output logic                  o_wb_ack
);
	// Command path
	logic                 cmd_push;
	logic [ALU_CMD_W-1:0] cmd_wr_data;
	logic                 cmd_full;
	logic                 cmd_pop;
	logic [ALU_CMD_W-1:0] cmd_rd_data;
	logic                 cmd_empty;

	// Result path
	logic                 res_push;
	logic [ALU_RES_W-1:0] res_wr_data;
	logic                 res_full;
	logic                 res_pop;
	logic [ALU_RES_W-1:0] res_rd_data;
	logic                 res_empty;

	alu_bus_port bus_port (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_adr    (i_wb_adr),
		.i_wb_dat    (i_wb_dat),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack),
		.o_cmd_push  (cmd_push),
		.o_cmd_data  (cmd_wr_data),
		.i_cmd_full  (cmd_full),
		.o_res_pop   (res_pop),
		.i_res_data  (res_rd_data),
		.i_res_empty (res_empty)
	);

	alu_queue #(.payload_t(logic [ALU_CMD_W-1:0])) cmd_queue (
		.clk     (clk),
		.reset_n (reset_n),
		.i_push  (cmd_push),
		.i_pop   (cmd_pop),
		.i_data  (cmd_wr_data),
		.o_data  (cmd_rd_data),
		.o_full  (cmd_full),
		.o_empty (cmd_empty)
	);

	alu_exec exec (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_cmd_data  (cmd_rd_data),
		.i_cmd_empty (cmd_empty),
		.o_cmd_pop   (cmd_pop),
		.o_res_push  (res_push),
		.o_res_data  (res_wr_data),
		.i_res_full  (res_full)
	);

	alu_queue #(.payload_t(logic [ALU_RES_W-1:0])) res_queue (
		.clk     (clk),
		.reset_n (reset_n),
		.i_push  (res_push),
		.i_pop   (res_pop),
		.i_data  (res_wr_data),
		.o_data  (res_rd_data),
		.o_full  (res_full),
		.o_empty (res_empty)
	);

endmodule

//--- tb_clock_gen.sv
// Testbench clock and active-low reset source, instantiated once by the ALU testbench
module tb_clock_gen
#(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 16
)
(
	output logic clk,
	output logic reset_n
);
	initial
	begin
		clk     = 1'b0;
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_n <= 1'b1;
	end

	always #HALF_PERIOD clk = ~clk;

endmodule

//--- alu_core_props.sv
// Concurrent checks on the Wishbone handshake and command queue use, bound into the bus port
module alu_core_props
(
	input logic clk,
	input logic reset_n,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_ack,
	input logic i_cmd_push,
	input logic i_cmd_full
);
	ack_low_in_reset: assert property (@(posedge clk) !reset_n |-> !i_wb_ack)
		else $error("bus ack high while in reset");

	// Ack is registered, so the request sits one cycle before it
	ack_needs_request: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(i_wb_ack) |-> $past(i_wb_cyc && i_wb_stb))
		else $error("bus ack rose without cyc and stb");

	ack_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		i_wb_ack |=> !i_wb_ack)
		else $error("bus ack high two cycles running");

	push_not_full: assert property (@(posedge clk) disable iff (!reset_n)
		i_cmd_push |-> !i_cmd_full)
		else $error("command pushed into a full queue");

endmodule

bind alu_bus_port alu_core_props props (
	.clk        (clk),
	.reset_n    (reset_n),
	.i_wb_cyc   (i_wb_cyc),
	.i_wb_stb   (i_wb_stb),
	.i_wb_ack   (o_wb_ack),
	.i_cmd_push (o_cmd_push),
	.i_cmd_full (i_cmd_full)
);

//--- tb_alu_core.sv
// Self-checking testbench that sends random ALU commands over Wishbone and checks each result
module tb_alu_core
	import alu_pkg::*;
();
	localparam int N_ARITH    = 48;
	localparam int N_LOGIC    = 48;
	localparam int N_DA       = 32;
	localparam int N_MUL      = 16;
	// Enough writes to fill both queues and the execution unit
	localparam int N_BURST    = 2 * ALU_QUEUE_DEPTH + 1;
	localparam int N_MIXED    = 64;
	localparam int N_TOTAL    = N_ARITH + N_LOGIC + N_DA + N_MUL + N_BURST + N_MIXED;
	localparam int CLK_PERIOD = 20;

	logic                  clk;
	logic                  reset_n;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [ALU_ADR_W-1:0]  wb_adr;
	logic [ALU_WORD_W-1:0] wb_dat_w;
	logic [ALU_WORD_W-1:0] wb_dat_r;
	logic                  wb_ack;

	int seed        = 65180;
	int test_pass   = 0;
	int test_fail   = 0;
	int test_errors = 0;
	int max_wait    = 0;
	logic [ALU_RES_W-1:0] expected_q [$];

	tb_clock_gen #(.HALF_PERIOD(CLK_PERIOD / 2), .RESET_CYCLES(16)) clock_gen (
		.clk     (clk),
		.reset_n (reset_n)
	);

	alu_core_top UUT (
		.clk      (clk),
		.reset_n  (reset_n),
		.i_wb_cyc (wb_cyc),
		.i_wb_stb (wb_stb),
		.i_wb_we  (wb_we),
		.i_wb_adr (wb_adr),
		.i_wb_dat (wb_dat_w),
		.o_wb_dat (wb_dat_r),
		.o_wb_ack (wb_ack)
	);

	function automatic int rand_below(input int span);
		return ($random(seed) & 32'h7fff_ffff) % span;
	endfunction

	// Random operands and flags with the chosen opcode
	function automatic logic [31:0] make_command(input int op);
		logic [31:0] word;
		word = $random(seed);
		word[ALU_CMD_OP_LSB +: ALU_OP_W] = op[ALU_OP_W-1:0];
		return word;
	endfunction

	// Reference model of the 8051 arithmetic rules
	function automatic logic [ALU_RES_W-1:0] expected_result(input logic [31:0] cmd);
		int a;
		int b;
		int cyi;
		int aci;
		int t;
		int low;
		int high;
		logic cy;
		logic ac;
		logic ov;
		logic [ALU_RES_W-1:0] res;
		a    = cmd[ALU_CMD_A_LSB +: ALU_BYTE_W];
		b    = cmd[ALU_CMD_B_LSB +: ALU_BYTE_W];
		cyi  = cmd[ALU_CMD_CY_BIT];
		aci  = cmd[ALU_CMD_AC_BIT];
		low  = a;
		high = 0;
		cy   = cyi[0];
		ac   = aci[0];
		ov   = 1'b0;
		case (alu_op_t'(cmd[ALU_CMD_OP_LSB +: ALU_OP_W]))
			OP_ADD, OP_ADDC:
			begin
				if (cmd[ALU_CMD_OP_LSB +: ALU_OP_W] == OP_ADD)
					cyi = 0;
				t   = a + b + cyi;
				low = t & 255;
				cy  = t > 255;
				ac  = ((a % 16) + (b % 16) + cyi) > 15;
				ov  = (((a % 128) + (b % 128) + cyi) > 127) != cy;
			end
			OP_SUBB:
			begin
				t   = a - b - cyi;
				low = t & 255;
				cy  = t < 0;
				ac  = ((a % 16) - (b % 16) - cyi) < 0;
				ov  = (((a % 128) - (b % 128) - cyi) < 0) != cy;
			end
			OP_AND:  low = a & b;
			OP_OR:   low = a | b;
			OP_XOR:  low = a ^ b;
			OP_CPL:  low = ~a & 255;
			OP_RR:   low = (a >> 1) | ((a & 1) << 7);
			OP_RL:   low = ((a << 1) | (a >> 7)) & 255;
			OP_RRC:
			begin
				low = (a >> 1) | (cyi << 7);
				cy  = (a & 1) != 0;
			end
			OP_RLC:
			begin
				low = ((a << 1) | cyi) & 255;
				cy  = a > 127;
			end
			OP_SWAP: low = (a % 16) * 16 + a / 16;
			OP_DA:
			begin
				t = a;
				if ((a % 16) > 9 || aci != 0)
					t += 6;
				if ((a / 16) > 9 || cyi != 0)
					t += 96;
				low = t & 255;
				cy  = t > 255 || cyi != 0;
			end
			OP_MUL:
			begin
				t    = a * b;
				low  = t % 256;
				high = t / 256;
				cy   = 1'b0;
				ov   = t > 255;
			end
			default: low = a;
		endcase
		res = '0;
		res[ALU_RES_LO_LSB +: ALU_BYTE_W] = low[7:0];
		res[ALU_RES_HI_LSB +: ALU_BYTE_W] = high[7:0];
		res[ALU_RES_P_BIT]  = ^low[7:0];
		res[ALU_RES_OV_BIT] = ov;
		res[ALU_RES_AC_BIT] = ac;
		res[ALU_RES_CY_BIT] = cy;
		return res;
	endfunction

	// One Wishbone classic cycle with ack and read data sampled on the falling edge
	task automatic bus_access(input logic we, input logic [ALU_ADR_W-1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		@(negedge clk);
		waited = 1;
		while (!wb_ack)
		begin
			@(negedge clk);
			waited++;
		end
		rdata = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		if (waited > max_wait)
			max_wait = waited;
	endtask

	task automatic issue_command(input logic [31:0] cmd);
		logic [31:0] unused;
		expected_q.push_back(expected_result(cmd));
		bus_access(1'b1, ALU_ADR_CMD, cmd, unused);
	endtask

	task automatic check_field(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (act == exp)
		else
		begin
			$display("ERR %s: expected 0x%h, got 0x%h", name, exp, act);
			test_errors++;
		end
	endtask

	task automatic collect_result();
		logic [31:0]          got;
		logic [ALU_RES_W-1:0] exp;
		bus_access(1'b0, ALU_ADR_RES, '0, got);
		exp = expected_q.pop_front();
		check_field("o_wb_dat.pad", 16'h0, 16'(got[ALU_WORD_W-1:ALU_RES_W]));
		check_field("o_wb_dat.lo", 16'(exp[ALU_RES_LO_LSB +: 8]), 16'(got[ALU_RES_LO_LSB +: 8]));
		check_field("o_wb_dat.hi", 16'(exp[ALU_RES_HI_LSB +: 8]), 16'(got[ALU_RES_HI_LSB +: 8]));
		check_field("o_wb_dat.p", 16'(exp[ALU_RES_P_BIT]), 16'(got[ALU_RES_P_BIT]));
		check_field("o_wb_dat.ov", 16'(exp[ALU_RES_OV_BIT]), 16'(got[ALU_RES_OV_BIT]));
		check_field("o_wb_dat.ac", 16'(exp[ALU_RES_AC_BIT]), 16'(got[ALU_RES_AC_BIT]));
		check_field("o_wb_dat.cy", 16'(exp[ALU_RES_CY_BIT]), 16'(got[ALU_RES_CY_BIT]));
	endtask

	task automatic finish_test(input string name, input int n);
		if (test_errors == 0)
		begin
			test_pass++;
			$display("%s: %0d commands, no errors", name, n);
		end
		else
		begin
			test_fail++;
			$display("%s: %0d commands, %0d errors", name, n, test_errors);
		end
		test_errors = 0;
	endtask

	// Write then read back, one command at a time
	task automatic run_ops(input string name, input int n, input int first_op, input int op_count);
		for (int i = 0; i < n; i++)
		begin
			issue_command(make_command(first_op + rand_below(op_count)));
			collect_result();
		end
		finish_test(name, n);
	endtask

	task automatic burst_test();
		max_wait = 0;
		for (int i = 0; i < N_BURST; i++)
			issue_command(make_command((i % 2 == 0) ? int'(OP_MUL) : rand_below(int'(OP_MUL))));
		// An access acked without delay is seen on its second falling edge
		assert (max_wait > 2)
		else
		begin
			$display("burst: no command write was held back by a full queue");
			test_errors++;
		end
		for (int i = 0; i < N_BURST; i++)
			collect_result();
		finish_test("burst", N_BURST);
	endtask

	initial
	begin
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		wait (reset_n === 1'b1);
		run_ops("arith", N_ARITH, OP_ADD, 3);
		run_ops("logic", N_LOGIC, OP_AND, 9);
		run_ops("da", N_DA, OP_DA, 1);
		run_ops("mul", N_MUL, OP_MUL, 1);
		burst_test();
		// All sixteen codes, the two unassigned ones included
		run_ops("mixed", N_MIXED, 0, 16);
		$display("tests: %0d passed, %0d failed", test_pass, test_fail);
		if (test_fail == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog sized from the command count
	initial
	begin
		#((N_TOTAL * 40 + 500) * CLK_PERIOD);
		$display("run timed out, a bus access never got its ack");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- filelist.f
alu_pkg.sv
alu_queue.sv
alu_bus_port.sv
alu_shift_add_mul.sv
alu_exec.sv
alu_core_top.sv
tb_clock_gen.sv
alu_core_props.sv
tb_alu_core.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_alu_core
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
